/* rv_core_golden.hex */
// Program section: word count, then instruction words from address 0
// Store section: record count, then per record address, data, preload flag
// Flag 1 means the expected data is the data column plus the preloaded word
25
00500093 FFD00113 20000513 002081B3 00352023 40208233 00452223 001122B3
00552423 0020C333 00652623 0020F3B3 00126433 008384B3 00952823 ABCDE5B7
1235E593 FFF5C613 00C52A23 0F05F693 FFE12713 00E686B3 00D52C23 04002783
00178793 04F02023 00108663 00152E23 00252E23 00109463 07700813 01052E23
00C008EF 02152023 02252023 03152023 00100073
0A
00000200 00000002 0
00000204 00000008 0
00000208 00000001 0
0000020C FFFFFFF8 0
00000210 00000012 0
00000214 54321EDC 0
00000218 00000021 0
00000040 00000001 1
0000021C 00000077 0
00000220 00000084 0

/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_stage_if.sv
rv_stage_id.sv
rv_hazard.sv
rv_stage_ex.sv
rv_stage_mem_wb.sv
rv_core.sv
rv_core_asserts.sv
rv_core_tb.sv

/* rv_core_tb.sv */
`include "rv_defs.svh"

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int IMEM_WORDS = 1 << `RV_IMEM_AW;
  localparam int DMEM_WORDS = 1 << `RV_DMEM_AW;
  localparam int GOLDEN_WORDS = 256;
  localparam int HALT_TIMEOUT = 2000;
  localparam int DRAIN_CYCLES = 16;

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;

  // Memory models and the golden image
  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] preload [0:DMEM_WORDS-1];
  logic [31:0] golden [0:GOLDEN_WORDS-1];

  logic [31:0] lfsr_state = 32'h89dce8b6;
  int          prog_cnt;
  int          store_cnt;
  int          stores_seen = 0;

  rv_core rv_core_i (.*);

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // Memory models, zero-latency read
  // ----------------------------------------------------------------------

  assign imem_rdata = imem[imem_raddr[`RV_IMEM_AW+1:2]];

  // Load data only while the core asks for it
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[`RV_DMEM_AW+1:2]] : 'x;

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[`RV_DMEM_AW+1:2]] <= dmem_wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Right-shifting Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  // One bit per step, MSB first
  task automatic draw_word(output logic [31:0] word);
    int b;
    word = '0;
    for (b = 0; b < 32; b++) begin
      word       = {word[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Compare one store with the next golden record
  task automatic check_store();
    int          base;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    if (ebreak) begin
      $display("A store appeared after ebreak rose");
      stop_with_failure();
    end
    if (stores_seen >= store_cnt) begin
      $display("More stores than the golden file lists");
      stop_with_failure();
    end
    base     = 2 + prog_cnt + 3 * stores_seen;
    exp_addr = golden[base];
    exp_data = golden[base + 1];
    // Load-then-use result builds on the LFSR word at that address
    if (golden[base + 2] != 32'd0) begin
      exp_data = exp_data + preload[exp_addr[`RV_DMEM_AW+1:2]];
    end
    check_value("dmem_waddr", dmem_waddr, exp_addr);
    check_value("dmem_wdata", dmem_wdata, exp_data);
    stores_seen++;
  endtask

  // Stores sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (rst_n && dmem_we) begin
      check_store();
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int          i;
    int          cycles;
    logic [31:0] word;
    clk   = 1'b0;
    rst_n = 1'b0;

    $readmemh("rv_core_golden.hex", golden);
    if ($isunknown(golden[0]) || golden[0] == 32'd0) begin
      $display("Golden file rv_core_golden.hex could not be read or is empty");
      stop_with_failure();
    end
    prog_cnt  = golden[0];
    store_cnt = golden[1 + prog_cnt];

    // Program, NOPs past its end
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog_cnt) ? golden[1 + i] : `RV_NOP;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      draw_word(word);
      dmem[i]    = word;
      preload[i] = word;
    end

    // Two reset cycles, quiet ports inside them
    @(posedge clk);
    @(negedge clk);
    check_value("imem_ren", imem_ren, 1'b0);
    check_value("dmem_we", dmem_we, 1'b0);
    check_value("dmem_ren", dmem_ren, 1'b0);
    check_value("ebreak", ebreak, 1'b0);
    @(posedge clk);
    #2 rst_n = 1'b1;

    // Fetch starts in the first cycle out of reset
    @(posedge clk);
    @(negedge clk);
    check_value("imem_ren", imem_ren, 1'b1);

    for (cycles = 0; cycles < HALT_TIMEOUT && !ebreak; cycles++) begin
      @(negedge clk);
    end
    if (!ebreak) begin
      $display("Timeout: ebreak never rose within %0d cycles", HALT_TIMEOUT);
      stop_with_failure();
    end

    // Halted core stays halted and silent
    for (cycles = 0; cycles < DRAIN_CYCLES; cycles++) begin
      @(negedge clk);
      check_value("ebreak", ebreak, 1'b1);
      check_value("imem_ren", imem_ren, 1'b0);
    end

    if (stores_seen == store_cnt && rv_core_i.core_asserts.failures == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else if (stores_seen != store_cnt) begin
      check_value("stores_seen", stores_seen, store_cnt);
    end else begin
      $display("%0d port assertions failed", rv_core_i.core_asserts.failures);
      stop_with_failure();
    end
  end

endmodule

/* rv_core_asserts.sv */
module rv_core_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] imem_raddr,
  input logic        dmem_ren,
  input logic        dmem_we,
  input logic [3:0]  dmem_wstrb,
  input logic        ebreak
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failure tally, read by the testbench at the end
  int unsigned failures = 0;

  // ----------------------------------------------------------------------
  // Memory port rules
  // ----------------------------------------------------------------------

  // One data access per cycle
  no_read_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_we && dmem_ren))
    else begin
      failures++;
      $error("dmem_we and dmem_ren high in the same cycle");
    end

  // Word stores only
  full_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> (dmem_wstrb == 4'hf))
    else begin
      failures++;
      $error("dmem_wstrb not all ones on a store");
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_raddr[1:0] == 2'b00)
    else begin
      failures++;
      $error("imem_raddr not word aligned");
    end

  // Halted core stores nothing
  quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |-> !dmem_we)
    else begin
      failures++;
      $error("dmem_we high after ebreak");
    end

endmodule

bind rv_core rv_core_asserts core_asserts (.*);

/* rv_core.sv */
module rv_core
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  output logic        imem_ren,
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,
  output logic        dmem_ren,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb,
  output logic        ebreak
);

  // ----------------------------------------------------------------------
  // Stage to stage wiring
  // ----------------------------------------------------------------------

  // Fetch to decode
  logic [31:0] instr_id;
  logic [31:0] pc_id;
  logic        halt_fetch;

  // Decode to hazard unit
  logic [4:0]  rs1_id;
  logic [4:0]  rs2_id;
  logic        rs1_used_id;
  logic        rs2_used_id;

  // Decode to execute
  logic        reg_write_ex;
  logic        mem_read_ex;
  logic        mem_write_ex;
  logic        is_branch_ex;
  logic        branch_ne_ex;
  logic        is_jump_ex;
  logic        is_ebreak_ex;
  rv_alu_op_e  alu_op_ex;
  logic        alu_b_imm_ex;
  rv_res_src_e res_src_ex;
  logic [4:0]  rd_ex;
  logic [31:0] rs1_data_ex;
  logic [31:0] rs2_data_ex;
  logic [31:0] imm_ex;
  logic [31:0] pc_ex;

  // Execute back to fetch
  logic        pc_sel;
  logic [31:0] redirect_target;

  // Execute to memory
  logic        reg_write_mem;
  logic        mem_read_mem;
  logic        mem_write_mem;
  logic        is_ebreak_mem;
  rv_res_src_e res_src_mem;
  logic [4:0]  rd_mem;
  logic [31:0] alu_result_mem;
  logic [31:0] rs2_data_mem;
  logic [31:0] pc_plus4_mem;

  // Write-back to register file
  logic [4:0]  rd_wb;
  logic        reg_write_wb;
  logic [31:0] rd_data_wb;

  // Interlock and flush
  logic        stall;
  logic        flush_id;
  logic        flush_ex;

  // ----------------------------------------------------------------------
  // Stages
  // ----------------------------------------------------------------------

  rv_stage_if stage_if (.*);

  rv_stage_id stage_id (.*);

  rv_hazard hazard (.*);

  rv_stage_ex stage_ex (.*);

  // Memory access and write-back together
  rv_stage_mem_wb stage_mem_wb (.*);

endmodule

/* rv_stage_mem_wb.sv */
module rv_stage_mem_wb
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        reg_write_mem,
  input  logic        mem_read_mem,
  input  logic        mem_write_mem,
  input  logic        is_ebreak_mem,
  input  rv_res_src_e res_src_mem,
  input  logic [4:0]  rd_mem,
  input  logic [31:0] alu_result_mem,
  input  logic [31:0] rs2_data_mem,
  input  logic [31:0] pc_plus4_mem,
  output logic        dmem_ren,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb,
  output logic [4:0]  rd_wb,
  output logic        reg_write_wb,
  output logic [31:0] rd_data_wb,
  output logic        ebreak
);

  rv_res_src_e res_src_wb;
  logic        is_ebreak_wb;
  logic [31:0] alu_result_wb;
  logic [31:0] load_data_wb;
  logic [31:0] pc_plus4_wb;

  // ----------------------------------------------------------------------
  // Data memory, zero-latency read
  // ----------------------------------------------------------------------

  assign dmem_ren   = mem_read_mem;
  assign dmem_raddr = alu_result_mem;
  assign dmem_we    = mem_write_mem;
  assign dmem_waddr = alu_result_mem;
  assign dmem_wdata = rs2_data_mem;
  // Full word stores only
  assign dmem_wstrb = {4{mem_write_mem}};

  // ----------------------------------------------------------------------
  // Memory to write-back register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_wb <= 1'b0;
      is_ebreak_wb <= 1'b0;
      res_src_wb   <= RES_ALU;
      rd_wb        <= 5'd0;
    end else begin
      reg_write_wb <= reg_write_mem;
      is_ebreak_wb <= is_ebreak_mem;
      res_src_wb   <= res_src_mem;
      rd_wb        <= rd_mem;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_wb <= alu_result_mem;
    load_data_wb  <= dmem_rdata;
    pc_plus4_wb   <= pc_plus4_mem;
  end

  // Write-back value select
  always_comb begin
    case (res_src_wb)
      RES_MEM:      rd_data_wb = load_data_wb;
      RES_PC_PLUS4: rd_data_wb = pc_plus4_wb;
      default:      rd_data_wb = alu_result_wb;
    endcase
  end

  // Halt flag, one cycle after EBREAK reaches write-back, held until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
    end else begin
      ebreak <= ebreak || is_ebreak_wb;
    end
  end

endmodule

/* rv_stage_ex.sv */
module rv_stage_ex
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        reg_write_ex,
  input  logic        mem_read_ex,
  input  logic        mem_write_ex,
  input  logic        is_branch_ex,
  input  logic        branch_ne_ex,
  input  logic        is_jump_ex,
  input  logic        is_ebreak_ex,
  input  rv_alu_op_e  alu_op_ex,
  input  logic        alu_b_imm_ex,
  input  rv_res_src_e res_src_ex,
  input  logic [4:0]  rd_ex,
  input  logic [31:0] rs1_data_ex,
  input  logic [31:0] rs2_data_ex,
  input  logic [31:0] imm_ex,
  input  logic [31:0] pc_ex,
  output logic        pc_sel,
  output logic [31:0] redirect_target,
  output logic        reg_write_mem,
  output logic        mem_read_mem,
  output logic        mem_write_mem,
  output logic        is_ebreak_mem,
  output rv_res_src_e res_src_mem,
  output logic [4:0]  rd_mem,
  output logic [31:0] alu_result_mem,
  output logic [31:0] rs2_data_mem,
  output logic [31:0] pc_plus4_mem
);

  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        operands_eq;
  logic        branch_taken;

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------

  assign alu_b = alu_b_imm_ex ? imm_ex : rs2_data_ex;

  always_comb begin
    case (alu_op_ex)
      ALU_ADD:    alu_result = rs1_data_ex + alu_b;
      ALU_SUB:    alu_result = rs1_data_ex - alu_b;
      ALU_AND:    alu_result = rs1_data_ex & alu_b;
      ALU_OR:     alu_result = rs1_data_ex | alu_b;
      ALU_XOR:    alu_result = rs1_data_ex ^ alu_b;
      ALU_SLT:    alu_result = {31'd0, $signed(rs1_data_ex) < $signed(alu_b)};
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Branch and jump resolution
  // ----------------------------------------------------------------------

  // BEQ on equal, BNE on not equal
  assign operands_eq     = (rs1_data_ex == rs2_data_ex);
  assign branch_taken    = is_branch_ex && (operands_eq ^ branch_ne_ex);
  assign pc_sel          = branch_taken || is_jump_ex;
  assign redirect_target = pc_ex + imm_ex;

  // ----------------------------------------------------------------------
  // Execute to memory register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_mem <= 1'b0;
      mem_read_mem  <= 1'b0;
      mem_write_mem <= 1'b0;
      is_ebreak_mem <= 1'b0;
      res_src_mem   <= RES_ALU;
      rd_mem        <= 5'd0;
    end else begin
      reg_write_mem <= reg_write_ex;
      mem_read_mem  <= mem_read_ex;
      mem_write_mem <= mem_write_ex;
      is_ebreak_mem <= is_ebreak_ex;
      res_src_mem   <= res_src_ex;
      rd_mem        <= rd_ex;
    end
  end

  // Results and store data
  always_ff @(posedge clk) begin
    alu_result_mem <= alu_result;
    rs2_data_mem   <= rs2_data_ex;
    pc_plus4_mem   <= pc_ex + 32'd4;
  end

endmodule

/* rv_hazard.sv */
module rv_hazard (
  input  logic [4:0] rs1_id,
  input  logic [4:0] rs2_id,
  input  logic       rs1_used_id,
  input  logic       rs2_used_id,
  input  logic [4:0] rd_ex,
  input  logic       reg_write_ex,
  input  logic [4:0] rd_mem,
  input  logic       reg_write_mem,
  input  logic       pc_sel,
  output logic       stall,
  output logic       flush_id,
  output logic       flush_ex
);

  logic rs1_pending;
  logic rs2_pending;

  // Source waits for a write still in execute or memory
  // Write-back needs no wait thanks to the register file write-through
  function automatic logic pending(input logic [4:0] rs, input logic used);
    logic hit_ex;
    logic hit_mem;
    hit_ex  = reg_write_ex && (rd_ex == rs);
    hit_mem = reg_write_mem && (rd_mem == rs);
    return used && (rs != 5'd0) && (hit_ex || hit_mem);
  endfunction

  assign rs1_pending = pending(rs1_id, rs1_used_id);
  assign rs2_pending = pending(rs2_id, rs2_used_id);

  // Taken branch or JAL kills the two younger slots
  assign flush_id = pc_sel;
  assign flush_ex = pc_sel;

  // Flushed decode slot has nothing to wait for
  assign stall = (rs1_pending || rs2_pending) && !pc_sel;

endmodule

/* rv_stage_id.sv */
module rv_stage_id
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] instr_id,
  input  logic [31:0] pc_id,
  input  logic        stall,
  input  logic        flush_ex,
  input  logic [4:0]  rd_wb,
  input  logic        reg_write_wb,
  input  logic [31:0] rd_data_wb,
  output logic [4:0]  rs1_id,
  output logic [4:0]  rs2_id,
  output logic        rs1_used_id,
  output logic        rs2_used_id,
  output logic        halt_fetch,
  output logic        reg_write_ex,
  output logic        mem_read_ex,
  output logic        mem_write_ex,
  output logic        is_branch_ex,
  output logic        branch_ne_ex,
  output logic        is_jump_ex,
  output logic        is_ebreak_ex,
  output rv_alu_op_e  alu_op_ex,
  output logic        alu_b_imm_ex,
  output rv_res_src_e res_src_ex,
  output logic [4:0]  rd_ex,
  output logic [31:0] rs1_data_ex,
  output logic [31:0] rs2_data_ex,
  output logic [31:0] imm_ex,
  output logic [31:0] pc_ex
);

  rv_instr_u   ins;
  logic        reg_write;
  logic        mem_read;
  logic        mem_write;
  logic        is_branch;
  logic        branch_ne;
  logic        is_jump;
  logic        is_ebreak;
  rv_alu_op_e  alu_op;
  logic        alu_b_imm;
  rv_res_src_e res_src;
  logic [31:0] imm;
  logic        bubble;

  // x1..x31, x0 is never stored
  logic [31:0] regs [1:31];

  assign ins    = instr_id;
  assign rs1_id = ins.r.rs1;
  assign rs2_id = ins.r.rs2;
  assign bubble = stall || flush_ex;

  // A flushed EBREAK must not stop fetch
  assign halt_fetch = is_ebreak && !flush_ex;

  // ----------------------------------------------------------------------
  // Decoder and immediates
  // ----------------------------------------------------------------------

  always_comb begin
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_branch   = 1'b0;
    branch_ne   = 1'b0;
    is_jump     = 1'b0;
    is_ebreak   = 1'b0;
    alu_op      = ALU_ADD;
    alu_b_imm   = 1'b0;
    res_src     = RES_ALU;
    rs1_used_id = 1'b0;
    rs2_used_id = 1'b0;
    imm         = '0;
    case (ins.r.opcode)
      OPC_OP, OPC_OP_IMM: begin
        reg_write   = 1'b1;
        rs1_used_id = 1'b1;
        // Register form reads rs2, immediate form uses imm
        alu_b_imm   = (ins.r.opcode == OPC_OP_IMM);
        rs2_used_id = !alu_b_imm;
        imm         = {{20{ins.i.imm[11]}}, ins.i.imm};
        case (ins.r.funct3)
          F3_ADD_SUB: begin
            // SUB only exists in the register form
            if (!alu_b_imm && ins.r.funct7 == F7_SUB) begin
              alu_op = ALU_SUB;
            end
          end
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: reg_write = 1'b0;
        endcase
      end
      OPC_LUI: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_op    = ALU_PASS_B;
        imm       = {ins.u.imm, 12'h000};
      end
      OPC_LOAD: begin
        // Word loads only
        reg_write   = (ins.i.funct3 == F3_LW);
        mem_read    = (ins.i.funct3 == F3_LW);
        rs1_used_id = 1'b1;
        alu_b_imm   = 1'b1;
        res_src     = RES_MEM;
        imm         = {{20{ins.i.imm[11]}}, ins.i.imm};
      end
      OPC_STORE: begin
        mem_write   = (ins.s.funct3 == F3_SW);
        rs1_used_id = 1'b1;
        rs2_used_id = 1'b1;
        alu_b_imm   = 1'b1;
        imm         = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
      end
      OPC_BRANCH: begin
        is_branch   = (ins.b.funct3 == F3_BEQ) || (ins.b.funct3 == F3_BNE);
        branch_ne   = (ins.b.funct3 == F3_BNE);
        rs1_used_id = 1'b1;
        rs2_used_id = 1'b1;
        imm         = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                       ins.b.imm4_1, 1'b0};
      end
      OPC_JAL: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        res_src   = RES_PC_PLUS4;
        imm       = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                     ins.j.imm10_1, 1'b0};
      end
      OPC_SYSTEM: begin
        is_ebreak = (ins.i.funct3 == F3_PRIV) && (ins.i.imm == F12_EBREAK);
      end
      default: begin
        // Unsupported opcode runs as a bubble
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reg_write_wb && rd_wb != 5'd0) begin
      regs[rd_wb] <= rd_data_wb;
    end
  end

  // Same-cycle write-back value goes straight through
  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    logic [31:0] val;
    if (addr == 5'd0) begin
      val = '0;
    end else if (reg_write_wb && rd_wb == addr) begin
      val = rd_data_wb;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  // ----------------------------------------------------------------------
  // Decode to execute register
  // ----------------------------------------------------------------------

  // Stall or flush leaves a cleared slot in execute
  always_ff @(posedge clk) begin
    if (!rst_n || bubble) begin
      reg_write_ex <= 1'b0;
      mem_read_ex  <= 1'b0;
      mem_write_ex <= 1'b0;
      is_branch_ex <= 1'b0;
      branch_ne_ex <= 1'b0;
      is_jump_ex   <= 1'b0;
      is_ebreak_ex <= 1'b0;
      alu_op_ex    <= ALU_ADD;
      alu_b_imm_ex <= 1'b0;
      res_src_ex   <= RES_ALU;
      rd_ex        <= 5'd0;
    end else begin
      reg_write_ex <= reg_write;
      mem_read_ex  <= mem_read;
      mem_write_ex <= mem_write;
      is_branch_ex <= is_branch;
      branch_ne_ex <= branch_ne;
      is_jump_ex   <= is_jump;
      is_ebreak_ex <= is_ebreak;
      alu_op_ex    <= alu_op;
      alu_b_imm_ex <= alu_b_imm;
      res_src_ex   <= res_src;
      rd_ex        <= ins.r.rd;
    end
  end

  // Operands and PC
  always_ff @(posedge clk) begin
    rs1_data_ex <= read_reg(rs1_id);
    rs2_data_ex <= read_reg(rs2_id);
    imm_ex      <= imm;
    pc_ex       <= pc_id;
  end

endmodule

/* rv_stage_if.sv */
`include "rv_defs.svh"

module rv_stage_if (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall,
  input  logic        flush_id,
  input  logic        pc_sel,
  input  logic [31:0] redirect_target,
  input  logic        halt_fetch,
  output logic        imem_ren,
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,
  output logic [31:0] instr_id,
  output logic [31:0] pc_id
);

  logic [31:0] pc;
  // Fetch running, off in reset and after EBREAK
  logic        fetch_en;
  // Sticky once EBREAK has passed decode
  logic        halted;
  logic        advance;

  // Move on only with a live fetch and no hold from decode
  assign advance    = fetch_en && !stall && !halt_fetch;
  assign imem_ren   = fetch_en;
  assign imem_raddr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en <= 1'b0;
      halted   <= 1'b0;
    end else begin
      fetch_en <= !(halted || halt_fetch);
      halted   <= halted || halt_fetch;
    end
  end

  // ----------------------------------------------------------------------
  // Program counter
  // ----------------------------------------------------------------------

  // Redirect wins over a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (pc_sel) begin
      pc <= redirect_target;
    end else if (advance) begin
      pc <= pc + 32'd4;
    end
  end

  // ----------------------------------------------------------------------
  // Fetch to decode register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n || flush_id) begin
      instr_id <= `RV_NOP;
    end else if (stall) begin
      // Hold the word being decoded
      instr_id <= instr_id;
    end else if (advance) begin
      instr_id <= imem_rdata;
    end else begin
      // Idle or halted fetch feeds bubbles
      instr_id <= `RV_NOP;
    end
  end

  // Fetch address of the word entering decode
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_id <= pc;
    end
  end

endmodule

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  // ----------------------------------------------------------------------
  // Control encodings passed down the pipeline
  // ----------------------------------------------------------------------

  // ALU function, picked in decode
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    // Operand B straight through, for LUI
    ALU_PASS_B = 3'd6
  } rv_alu_op_e;

  // Source of the register write-back value
  typedef enum logic [1:0] {
    RES_ALU      = 2'd0,
    RES_MEM      = 2'd1,
    // Link address of JAL
    RES_PC_PLUS4 = 2'd2
  } rv_res_src_e;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // ----------------------------------------------------------------------
  // Instruction formats, MSB first
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  // Branch offset bits scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  // One fetched word, viewed in every format
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_instr_u;

  // ----------------------------------------------------------------------
  // Opcodes
  // ----------------------------------------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 and funct7 values of the supported subset
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_PRIV    = 3'b000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // EBREAK lives in the I-format immediate
  localparam logic [11:0] F12_EBREAK = 12'h001;

endpackage

/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ----------------------------------------------------------------------
// Core-wide sizes and constants
// ----------------------------------------------------------------------

// Instruction memory depth in words, as an address width
`define RV_IMEM_AW 10

// Data memory depth in words, as an address width
`define RV_DMEM_AW 10

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// ADDI x0,x0,0
// Filler for flushed and empty pipeline slots
`define RV_NOP 32'h0000_0013

`endif
